// ==== Makefile ====
# Verilator flow for the lcm project

VERILATOR ?= verilator
TB_TOP    ?= lcm_tb
RTL_TOP   ?= lcm
FILELIST  ?= lcm.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SHELL       := /bin/bash
.SHELLFLAGS := -o pipefail -c

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "result: FAIL"; exit 1; fi
	@echo "result: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/cqf_slot_timer.sv ====
// a period lowered below the running count wraps at once, so the first slot after a write is short
`timescale 1ns/1ps

module cqf_slot_timer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  lcm_pkg::slot_period_t  time_slot_period,
	output logic                   time_slot_flag
);
	import lcm_pkg::*;

	// cycles since the last wrap
	slot_period_t slot_cnt;
	logic         slot_wrap;

	// count runs 0..period, so one slot is period+1 cycles
	assign slot_wrap = (slot_cnt >= time_slot_period);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot_cnt       <= '0;
			time_slot_flag <= 1'b0;
		end else if (slot_wrap) begin
			slot_cnt       <= '0;
			// odd and even slots for cqf
			time_slot_flag <= ~time_slot_flag;
		end else begin
			slot_cnt <= slot_cnt + 16'd1;
		end
	end

endmodule

// ==== hdl/lcm.sv ====
// two cycle latency for forwarded words, no egress back-pressure, one report pending at a time
`timescale 1ns/1ps
`include "lcm_config.svh"

module lcm #(
	parameter lcm_pkg::lmid_t lmid = `LCM_LMID_DEF
) (
	input  logic                   clk,
	input  logic                   rst_n,
	// from the parser
	input  lcm_pkg::lcm_word_t     in_data,
	input  logic                   in_data_wr,
	input  logic                   in_valid,
	input  logic                   in_valid_wr,
	output logic                   pktin_ready,
	// to the egress switch
	output lcm_pkg::lcm_word_t     out_data,
	output logic                   out_data_wr,
	output logic                   out_valid,
	output logic                   out_valid_wr,
	// status for the report
	input  lcm_pkg::ptime_t        precision_time,
	input  lcm_pkg::mac_addr_t     in_local_mac,
	input  lcm_pkg::cnt64_t        esw_pktin_cnt,
	input  lcm_pkg::cnt64_t        goe_discard_cnt,
	input  lcm_pkg::q_used_t       eos_q_used,
	// control registers
	output logic                   direction,
	output lcm_pkg::tb_para_t      token_bucket_para,
	output lcm_pkg::mac_addr_t     direct_mac_addr,
	output logic                   time_slot_flag
);
	import lcm_pkg::*;

	// report to update stage
	lcm_word_t    rpt_data;
	logic         rpt_data_wr;
	logic         rpt_valid;
	logic         rpt_valid_wr;
	msg_class_e   rpt_class;

	slot_period_t time_slot_period;

	// **************************************************
	// report stage
	// **************************************************
	lcm_report #(
		.lmid(lmid)
	) u_report (
		.clk             (clk),
		.rst_n           (rst_n),
		.in_data         (in_data),
		.in_data_wr      (in_data_wr),
		.in_valid        (in_valid),
		.in_valid_wr     (in_valid_wr),
		.pktin_ready     (pktin_ready),
		.precision_time  (precision_time),
		.in_local_mac    (in_local_mac),
		.esw_pktin_cnt   (esw_pktin_cnt),
		.goe_discard_cnt (goe_discard_cnt),
		.eos_q_used      (eos_q_used),
		.rpt_data        (rpt_data),
		.rpt_data_wr     (rpt_data_wr),
		.rpt_valid       (rpt_valid),
		.rpt_valid_wr    (rpt_valid_wr),
		.rpt_class       (rpt_class)
	);

	// update stage owns the registers
	lcm_update u_update (
		.clk               (clk),
		.rst_n             (rst_n),
		.rpt_data          (rpt_data),
		.rpt_data_wr       (rpt_data_wr),
		.rpt_valid         (rpt_valid),
		.rpt_valid_wr      (rpt_valid_wr),
		.rpt_class         (rpt_class),
		.out_data          (out_data),
		.out_data_wr       (out_data_wr),
		.out_valid         (out_valid),
		.out_valid_wr      (out_valid_wr),
		.direction         (direction),
		.token_bucket_para (token_bucket_para),
		.direct_mac_addr   (direct_mac_addr),
		.time_slot_period  (time_slot_period)
	);

	// slot reference for cqf
	cqf_slot_timer u_slot_timer (
		.clk              (clk),
		.rst_n            (rst_n),
		.time_slot_period (time_slot_period),
		.time_slot_flag   (time_slot_flag)
	);

endmodule

// ==== hdl/lcm_config.svh ====
// beacon codes and register reset values shared by the lcm stages, lmid is 8 bits wide
`ifndef LCM_CONFIG_SVH
`define LCM_CONFIG_SVH

// **************************************************
// beacon identification
// **************************************************

// ethertype carried by every beacon head
`define LCM_ETHERTYPE   16'h1662

// subtype codes in head data 15:8
`define LCM_SUB_READ    8'd1
`define LCM_SUB_WRITE   8'd2
`define LCM_SUB_REPORT  8'd3

// module id this instance answers to by default
`define LCM_LMID_DEF    8'd1

// bus tag in word bits 133:132
`define LCM_TAG_HEAD    2'b01
`define LCM_TAG_BODY    2'b11
`define LCM_TAG_TAIL    2'b10

// **************************************************
// control register reset values
// **************************************************

// 0x7a12 cycles gives roughly a 250 us slot at 125 MHz
`define LCM_SLOT_RST    16'h7a12
`define LCM_TB_RST      32'd0

`endif

// ==== hdl/lcm_pkg.sv ====
// types for the local control module, word layout fixed at 134 bits with the tag on top
package lcm_pkg;

	// **************************************************
	// bus and field widths
	// **************************************************

	// tag 133:132, invalid byte count 131:128, data 127:0
	typedef logic [133:0] lcm_word_t;

	// two bit word tag
	typedef logic [1:0]   pkt_tag_t;

	typedef logic [47:0]  mac_addr_t;

	// precision time from the sync block
	typedef logic [47:0]  ptime_t;

	typedef logic [63:0]  cnt64_t;

	// four 6 bit queue fills, queue 0 lowest
	typedef logic [23:0]  q_used_t;

	typedef logic [31:0]  tb_para_t;

	// slot length in clock cycles
	typedef logic [15:0]  slot_period_t;

	// head fields
	typedef logic [15:0]  ethertype_t;
	typedef logic [7:0]   subtype_t;
	typedef logic [7:0]   lmid_t;

	// **************************************************
	// enums
	// **************************************************

	// qualifier riding with every word between the stages
	typedef enum logic {
		msg_forward,
		msg_update
	} msg_class_e;

	// report packet generator
	typedef enum logic [1:0] {
		rpt_idle,
		rpt_head,
		rpt_body,
		rpt_tail
	} rpt_state_e;

endpackage

// ==== hdl/lcm_report.sv ====
// classifies on the head only, one report in flight at a time, upstream must honour pktin_ready
`timescale 1ns/1ps
`include "lcm_config.svh"

module lcm_report #(
	parameter lcm_pkg::lmid_t lmid = `LCM_LMID_DEF
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  lcm_pkg::lcm_word_t     in_data,
	input  logic                   in_data_wr,
	input  logic                   in_valid,
	input  logic                   in_valid_wr,
	output logic                   pktin_ready,
	input  lcm_pkg::ptime_t        precision_time,
	input  lcm_pkg::mac_addr_t     in_local_mac,
	input  lcm_pkg::cnt64_t        esw_pktin_cnt,
	input  lcm_pkg::cnt64_t        goe_discard_cnt,
	input  lcm_pkg::q_used_t       eos_q_used,
	output lcm_pkg::lcm_word_t     rpt_data,
	output logic                   rpt_data_wr,
	output logic                   rpt_valid,
	output logic                   rpt_valid_wr,
	output lcm_pkg::msg_class_e    rpt_class
);
	import lcm_pkg::*;

	// head field views
	pkt_tag_t   in_tag;
	ethertype_t head_ethertype;
	subtype_t   head_subtype;
	lmid_t      head_lmid;
	logic       is_head;
	logic       is_tail;
	logic       is_beacon;

	// class of the current word and the one held for the packet
	msg_class_e head_class;
	msg_class_e word_class;
	msg_class_e cur_class;
	logic       head_drop;
	logic       word_drop;
	logic       cur_drop;
	logic       read_tail;

	// report generator
	rpt_state_e rpt_state;
	logic       rpt_sent;
	mac_addr_t  req_src_mac;
	ptime_t     snap_time;
	q_used_t    snap_q_used;
	cnt64_t     snap_pktin;
	cnt64_t     snap_discard;
	lcm_word_t  head_word;
	lcm_word_t  body_word;
	lcm_word_t  tail_word;

	// **************************************************
	// classification
	// **************************************************
	assign in_tag         = in_data[133:132];
	assign head_ethertype = in_data[31:16];
	assign head_subtype   = in_data[15:8];
	assign head_lmid      = in_data[7:0];
	assign is_head        = in_data_wr && (in_tag == `LCM_TAG_HEAD);
	assign is_tail        = in_data_wr && (in_tag == `LCM_TAG_TAIL);

	// only our own beacons are acted on
	assign is_beacon  = (head_ethertype == `LCM_ETHERTYPE) && (head_lmid == lmid);
	assign head_class = (is_beacon && head_subtype == `LCM_SUB_WRITE) ? msg_update : msg_forward;
	assign head_drop  = is_beacon && (head_subtype == `LCM_SUB_READ);

	// head decides for itself, later words use the held class
	assign word_class = is_head ? head_class : cur_class;
	assign word_drop  = is_head ? head_drop : cur_drop;
	assign read_tail  = is_tail && word_drop;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cur_class <= msg_forward;
			cur_drop  <= 1'b0;
		end else if (is_head) begin
			cur_class <= head_class;
			cur_drop  <= head_drop;
		end
	end

	// requester mac becomes the report destination
	always_ff @(posedge clk) begin
		if (is_head && head_drop) begin
			req_src_mac <= in_data[79:32];
		end
	end

	// **************************************************
	// report fsm
	// **************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rpt_state   <= rpt_idle;
			rpt_sent    <= 1'b0;
			pktin_ready <= 1'b1;
		end else begin
			// one cycle after the report tail goes out
			rpt_sent <= (rpt_state == rpt_tail);
			if (read_tail) begin
				pktin_ready <= 1'b0;
			end else if (rpt_sent) begin
				pktin_ready <= 1'b1;
			end
			case (rpt_state)
				rpt_idle: if (read_tail) rpt_state <= rpt_head;
				rpt_head: rpt_state <= rpt_body;
				rpt_body: rpt_state <= rpt_tail;
				default:  rpt_state <= rpt_idle;
			endcase
		end
	end

	// time and counters frozen as the head is built
	always_ff @(posedge clk) begin
		if (rpt_state == rpt_head) begin
			snap_time    <= precision_time;
			snap_q_used  <= eos_q_used;
			snap_pktin   <= esw_pktin_cnt;
			snap_discard <= goe_discard_cnt;
		end
	end

	assign head_word = {`LCM_TAG_HEAD, 4'd0, req_src_mac, in_local_mac,
		`LCM_ETHERTYPE, `LCM_SUB_REPORT, lmid};
	// body has time then queue fills, zero below
	assign body_word = {`LCM_TAG_BODY, 4'd0, snap_time, snap_q_used, 56'd0};
	assign tail_word = {`LCM_TAG_TAIL, 4'd0, snap_pktin, snap_discard};

	// **************************************************
	// output stage
	// **************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rpt_data_wr  <= 1'b0;
			rpt_valid_wr <= 1'b0;
			rpt_valid    <= 1'b0;
			rpt_class    <= msg_forward;
		end else if (rpt_state != rpt_idle) begin
			// report words leave as ordinary traffic
			rpt_data_wr  <= 1'b1;
			rpt_valid_wr <= (rpt_state == rpt_tail);
			rpt_valid    <= (rpt_state == rpt_tail);
			rpt_class    <= msg_forward;
		end else begin
			rpt_data_wr  <= in_data_wr && !word_drop;
			rpt_valid_wr <= in_valid_wr && !word_drop;
			rpt_valid    <= in_valid;
			rpt_class    <= word_class;
		end
	end

	always_ff @(posedge clk) begin
		case (rpt_state)
			rpt_head: rpt_data <= head_word;
			rpt_body: rpt_data <= body_word;
			rpt_tail: rpt_data <= tail_word;
			default:  rpt_data <= in_data;
		endcase
	end

endmodule

// ==== hdl/lcm_update.sv ====
// update fields come from the first body word only, an update without a body is ignored
`timescale 1ns/1ps
`include "lcm_config.svh"

module lcm_update (
	input  logic                   clk,
	input  logic                   rst_n,
	input  lcm_pkg::lcm_word_t     rpt_data,
	input  logic                   rpt_data_wr,
	input  logic                   rpt_valid,
	input  logic                   rpt_valid_wr,
	input  lcm_pkg::msg_class_e    rpt_class,
	output lcm_pkg::lcm_word_t     out_data,
	output logic                   out_data_wr,
	output logic                   out_valid,
	output logic                   out_valid_wr,
	output logic                   direction,
	output lcm_pkg::tb_para_t      token_bucket_para,
	output lcm_pkg::mac_addr_t     direct_mac_addr,
	output lcm_pkg::slot_period_t  time_slot_period
);
	import lcm_pkg::*;

	pkt_tag_t     rpt_tag;
	logic         is_fwd;
	logic         upd_word;
	logic         upd_head;
	logic         upd_body;
	logic         upd_tail;

	// fields as laid out in the update body
	logic         body_direction;
	tb_para_t     body_tb_para;
	mac_addr_t    body_mac;
	slot_period_t body_period;

	// shadow copy waiting for the tail
	logic         shadow_valid;
	logic         shadow_direction;
	tb_para_t     shadow_tb_para;
	mac_addr_t    shadow_mac;
	slot_period_t shadow_period;

	// **************************************************
	// word decode
	// **************************************************
	assign rpt_tag  = rpt_data[133:132];
	assign is_fwd   = (rpt_class == msg_forward);
	assign upd_word = rpt_data_wr && (rpt_class == msg_update);
	assign upd_head = upd_word && (rpt_tag == `LCM_TAG_HEAD);
	assign upd_body = upd_word && (rpt_tag == `LCM_TAG_BODY);
	assign upd_tail = upd_word && (rpt_tag == `LCM_TAG_TAIL);

	assign body_direction = rpt_data[127];
	assign body_tb_para   = rpt_data[126:95];
	assign body_mac       = rpt_data[94:47];
	assign body_period    = rpt_data[46:31];

	// **************************************************
	// forwarding stage
	// **************************************************
	// update words are swallowed here
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_data_wr  <= 1'b0;
			out_valid_wr <= 1'b0;
			out_valid    <= 1'b0;
		end else begin
			out_data_wr  <= rpt_data_wr && is_fwd;
			out_valid_wr <= rpt_valid_wr && is_fwd;
			out_valid    <= rpt_valid;
		end
	end

	always_ff @(posedge clk) begin
		out_data <= rpt_data;
	end

	// **************************************************
	// shadow and live registers
	// **************************************************
	// later bodies leave the shadow alone
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shadow_valid <= 1'b0;
		end else if (upd_head || upd_tail) begin
			shadow_valid <= 1'b0;
		end else if (upd_body) begin
			shadow_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (upd_body && !shadow_valid) begin
			shadow_direction <= body_direction;
			shadow_tb_para   <= body_tb_para;
			shadow_mac       <= body_mac;
			shadow_period    <= body_period;
		end
	end

	// commit on the tail
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			direction         <= 1'b0;
			token_bucket_para <= `LCM_TB_RST;
			direct_mac_addr   <= '0;
			time_slot_period  <= `LCM_SLOT_RST;
		end else if (upd_tail && shadow_valid) begin
			direction         <= shadow_direction;
			token_bucket_para <= shadow_tb_para;
			direct_mac_addr   <= shadow_mac;
			time_slot_period  <= shadow_period;
		end
	end

endmodule

// ==== lcm.f ====
+incdir+hdl
hdl/lcm_pkg.sv
hdl/cqf_slot_timer.sv
hdl/lcm_report.sv
hdl/lcm_update.sv
hdl/lcm.sv
tb/tb_clk_gen.sv
tb/lcm_props.sv
tb/lcm_tb.sv

// ==== tb/lcm_props.sv ====
// framing checks sampled on the rising clock, bound into every lcm instance
`timescale 1ns/1ps
`include "lcm_config.svh"

module lcm_props (
	input logic                clk,
	input logic                rst_n,
	input lcm_pkg::lcm_word_t  in_data,
	input logic                in_data_wr,
	input logic                pktin_ready,
	input lcm_pkg::lcm_word_t  out_data,
	input logic                out_valid_wr
);

	// **************************************************
	// output framing
	// **************************************************
	// valid strobe belongs to the last word only
	a_valid_wr_on_tail: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid_wr |-> out_data[133:132] == `LCM_TAG_TAIL)
		else $error("out_valid_wr seen on a word without a tail tag");

	// **************************************************
	// input handshake
	// **************************************************
	// upstream may finish a packet but not start one
	a_no_head_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
		in_data_wr && in_data[133:132] == `LCM_TAG_HEAD |-> pktin_ready)
		else $error("head word accepted while pktin_ready was low");

	// two cycles after release
	a_ready_after_reset: assert property (@(posedge clk)
		$past(rst_n, 2) && !$past(rst_n, 3) |-> pktin_ready)
		else $error("pktin_ready not high two cycles after reset");

endmodule

bind lcm lcm_props u_props (.*);

// ==== tb/lcm_tb.sv ====
// lcm with the default lmid, one packet in flight per test, out_ bus sampled on the falling edge
`timescale 1ns/1ps
`include "lcm_config.svh"

module lcm_tb;
	import lcm_pkg::*;

	localparam int NTEST      = 10;
	localparam int WAIT_MAX   = 40;
	localparam int TOGGLE_MAX = 100;

	typedef enum logic [2:0] {k_fwd, k_foreign, k_write, k_read, k_slot} kind_e;

	// one row of the stimulus table
	typedef struct packed {
		kind_e        kind;
		logic [7:0]   nbody;
		lmid_t        mid;
		subtype_t     sub;
		ethertype_t   etype;
		logic         dir;
		tb_para_t     para;
		mac_addr_t    mac;
		slot_period_t period;
		// register image after the test
		logic         exp_dir;
		tb_para_t     exp_para;
		mac_addr_t    exp_mac;
		slot_period_t exp_period;
	} test_t;

	logic         clk;
	logic         rst_n;
	lcm_word_t    in_data;
	logic         in_data_wr;
	logic         in_valid;
	logic         in_valid_wr;
	logic         pktin_ready;
	lcm_word_t    out_data;
	logic         out_data_wr;
	logic         out_valid;
	logic         out_valid_wr;
	ptime_t       precision_time;
	mac_addr_t    in_local_mac;
	cnt64_t       esw_pktin_cnt;
	cnt64_t       goe_discard_cnt;
	q_used_t      eos_q_used;
	logic         direction;
	tb_para_t     token_bucket_para;
	mac_addr_t    direct_mac_addr;
	logic         time_slot_flag;

	integer       seed;
	int           cyc;
	int           errors;
	int           checks;
	test_t        tbl [NTEST];

	// expected out_ words from the model
	lcm_word_t    exp_word [$];
	logic         exp_vwr [$];
	logic         exp_valid [$];
	int           exp_cyc [$];

	// model of the control registers
	logic         m_dir;
	tb_para_t     m_para;
	mac_addr_t    m_mac;
	slot_period_t m_period;

	tb_clk_gen u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	lcm dut (.*);

	always @(posedge clk) cyc <= cyc + 1;

	// **************************************************
	// compare tasks
	// **************************************************
	task automatic check_word(input string name, input lcm_word_t got, input lcm_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic check_mac(input string name, input mac_addr_t got, input mac_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic check_para(input string name, input tb_para_t got, input tb_para_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic check_period(input string name, input slot_period_t got,
		input slot_period_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic check_cycle(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("error %s got %h exp %h", name, got, exp);
		end
	endtask

	// **************************************************
	// monitor
	// **************************************************
	always @(negedge clk) begin : monitor
		logic vwr;
		logic vexp;
		if (rst_n === 1'b1 && out_data_wr === 1'b1) begin
			if (exp_word.size() == 0) begin
				errors++;
				$display("unexpected word on out_data at cycle %0d", cyc);
			end else begin
				vwr  = exp_vwr.pop_front();
				vexp = exp_valid.pop_front();
				check_word("out_data", out_data, exp_word.pop_front());
				check_bit("out_valid_wr", out_valid_wr, vwr);
				// valid only means something with the strobe
				if (vwr) begin
					check_bit("out_valid", out_valid, vexp);
				end
				check_cycle("out_data cycle", cyc, exp_cyc.pop_front());
			end
		end
	end

	// **************************************************
	// helpers
	// **************************************************
	function automatic logic [31:0] rnd();
		return $random(seed);
	endfunction

	function automatic string kind_label(input kind_e k);
		case (k)
			k_fwd:     return "forward";
			k_foreign: return "foreign beacon";
			k_write:   return "write";
			k_read:    return "read";
			default:   return "slot";
		endcase
	endfunction

	task automatic expect_word(input lcm_word_t w, input logic vwr, input logic v, input int at);
		exp_word.push_back(w);
		exp_vwr.push_back(vwr);
		exp_valid.push_back(v);
		exp_cyc.push_back(at);
	endtask

	// all driving starts 1 ns after a rising edge
	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic drive_word(input lcm_word_t w, input logic last, input logic v);
		in_data     = w;
		in_data_wr  = 1'b1;
		in_valid_wr = last;
		in_valid    = last & v;
		idle(1);
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (pktin_ready !== 1'b1 && n < WAIT_MAX) begin
			idle(1);
			n++;
		end
		if (pktin_ready !== 1'b1) begin
			errors++;
			$display("timeout waiting for pktin_ready to rise");
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_word.size() > 0 && n < WAIT_MAX) begin
			idle(1);
			n++;
		end
		if (exp_word.size() > 0) begin
			errors++;
			$display("timeout, %0d expected words never left out_data", exp_word.size());
			exp_word.delete();
			exp_vwr.delete();
			exp_valid.delete();
			exp_cyc.delete();
		end
	endtask

	task automatic wait_toggle(output int at);
		logic prev;
		int   n;
		prev = time_slot_flag;
		n    = 0;
		at   = -1;
		while (at < 0 && n < TOGGLE_MAX) begin
			@(negedge clk);
			n++;
			if (time_slot_flag !== prev) begin
				at = cyc;
			end
		end
		if (at < 0) begin
			errors++;
			$display("timeout waiting for time_slot_flag to toggle");
		end
	endtask

	// report inputs, held for the whole test
	task automatic set_status();
		logic [63:0] r64;
		r64 = {rnd(), rnd()};
		precision_time = r64[47:0];
		r64 = {rnd(), rnd()};
		in_local_mac = r64[47:0];
		esw_pktin_cnt   = {rnd(), rnd()};
		goe_discard_cnt = {rnd(), rnd()};
		r64 = {rnd(), rnd()};
		eos_q_used = r64[23:0];
	endtask

	task automatic add_test(input int t, input kind_e kind, input logic [7:0] nbody,
		input lmid_t mid, input subtype_t sub, input ethertype_t etype,
		input slot_period_t period);
		logic [63:0] r64;
		tbl[t].kind   = kind;
		tbl[t].nbody  = nbody;
		tbl[t].mid    = mid;
		tbl[t].sub    = sub;
		tbl[t].etype  = etype;
		r64 = {rnd(), rnd()};
		tbl[t].dir    = r64[63];
		tbl[t].para   = r64[31:0];
		r64 = {rnd(), rnd()};
		tbl[t].mac    = r64[47:0];
		tbl[t].period = period;
		// own write beacon loads on its tail
		if (kind == k_write || kind == k_slot) begin
			m_dir    = tbl[t].dir;
			m_para   = tbl[t].para;
			m_mac    = tbl[t].mac;
			m_period = period;
		end
		tbl[t].exp_dir    = m_dir;
		tbl[t].exp_para   = m_para;
		tbl[t].exp_mac    = m_mac;
		tbl[t].exp_period = m_period;
	endtask

	// **************************************************
	// one test from the table
	// **************************************************
	task automatic run_test(input int t);
		test_t       e;
		lcm_word_t   pkt [$];
		mac_addr_t   src;
		logic [63:0] r64;
		logic [31:0] r;
		logic        v;
		logic        last;
		int          err0;
		int          t0;
		int          t1;
		int          t2;
		e    = tbl[t];
		err0 = errors;
		set_status();
		r64 = {rnd(), rnd()};
		src = r64[47:0];
		r64 = {rnd(), rnd()};
		pkt.push_back({`LCM_TAG_HEAD, 4'd0, r64[47:0], src, e.etype, e.sub, e.mid});
		for (int i = 0; i < int'(e.nbody); i++) begin
			r = rnd();
			// update fields sit in the first body
			if (i == 0 && (e.kind == k_write || e.kind == k_slot)) begin
				pkt.push_back({`LCM_TAG_BODY, 4'd0, e.dir, e.para, e.mac, e.period, r[30:0]});
			end else begin
				pkt.push_back({`LCM_TAG_BODY, 4'd0, r, rnd(), rnd(), rnd()});
			end
		end
		r = rnd();
		v = r[4];
		pkt.push_back({`LCM_TAG_TAIL, r[3:0], rnd(), rnd(), rnd(), rnd()});
		wait_ready();
		for (int i = 0; i < pkt.size(); i++) begin
			last = (i == pkt.size() - 1);
			// forwarded words come out unchanged two cycles later
			if (e.kind == k_fwd || e.kind == k_foreign) begin
				expect_word(pkt[i], last, v, cyc + 2);
			end
			drive_word(pkt[i], last, v);
		end
		in_data_wr  = 1'b0;
		in_valid_wr = 1'b0;
		in_valid    = 1'b0;
		// report head three cycles after the request tail
		if (e.kind == k_read) begin
			expect_word({`LCM_TAG_HEAD, 4'd0, src, in_local_mac, `LCM_ETHERTYPE,
				`LCM_SUB_REPORT, `LCM_LMID_DEF}, 1'b0, 1'b0, cyc + 2);
			expect_word({`LCM_TAG_BODY, 4'd0, precision_time, eos_q_used, 56'd0},
				1'b0, 1'b0, cyc + 3);
			expect_word({`LCM_TAG_TAIL, 4'd0, esw_pktin_cnt, goe_discard_cnt},
				1'b1, 1'b1, cyc + 4);
			check_bit("pktin_ready", pktin_ready, 1'b0);
			wait_ready();
		end
		wait_drain();
		// registers settle two cycles after the tail
		idle(3);
		check_bit("direction", direction, e.exp_dir);
		check_para("token_bucket_para", token_bucket_para, e.exp_para);
		check_mac("direct_mac_addr", direct_mac_addr, e.exp_mac);
		check_period("time_slot_period", dut.time_slot_period, e.exp_period);
		if (e.kind == k_slot) begin
			wait_toggle(t0);
			wait_toggle(t1);
			wait_toggle(t2);
			// period+1 cycles between toggles
			check_period("slot length", slot_period_t'(t1 - t0 - 1), e.period);
			check_period("slot length", slot_period_t'(t2 - t1 - 1), e.period);
			idle(1);
		end
		$display("test %0d %s: %s", t, kind_label(e.kind), (errors == err0) ? "ok" : "mismatch");
	endtask

	// **************************************************
	// main sequence
	// **************************************************
	initial begin
		logic [31:0] rp;
		int          n;
		int          err0;
		seed            = 11;
		cyc             = 0;
		errors          = 0;
		checks          = 0;
		in_data         = '0;
		in_data_wr      = 1'b0;
		in_valid        = 1'b0;
		in_valid_wr     = 1'b0;
		precision_time  = '0;
		in_local_mac    = '0;
		esw_pktin_cnt   = '0;
		goe_discard_cnt = '0;
		eos_q_used      = '0;
		m_dir           = 1'b0;
		m_para          = `LCM_TB_RST;
		m_mac           = '0;
		m_period        = `LCM_SLOT_RST;
		rp = rnd();
		add_test(0, k_fwd,     8'd2, 8'd1, `LCM_SUB_WRITE, 16'h0800, 16'd0);
		add_test(1, k_foreign, 8'd1, 8'd7, `LCM_SUB_WRITE, `LCM_ETHERTYPE, 16'd0);
		add_test(2, k_write,   8'd2, 8'd1, `LCM_SUB_WRITE, `LCM_ETHERTYPE, rp[15:0]);
		add_test(3, k_read,    8'd1, 8'd1, `LCM_SUB_READ, `LCM_ETHERTYPE, 16'd0);
		add_test(4, k_foreign, 8'd0, 8'd3, `LCM_SUB_READ, `LCM_ETHERTYPE, 16'd0);
		add_test(5, k_fwd,     8'd3, 8'd1, `LCM_SUB_READ, 16'h86dd, 16'd0);
		add_test(6, k_read,    8'd0, 8'd1, `LCM_SUB_READ, `LCM_ETHERTYPE, 16'd0);
		add_test(7, k_slot,    8'd1, 8'd1, `LCM_SUB_WRITE, `LCM_ETHERTYPE, 16'd9);
		add_test(8, k_fwd,     8'd1, 8'd2, `LCM_SUB_REPORT, 16'h0806, 16'd0);
		add_test(9, k_slot,    8'd2, 8'd1, `LCM_SUB_WRITE, `LCM_ETHERTYPE, 16'd20);
		n = 0;
		while (rst_n !== 1'b1 && n < WAIT_MAX) begin
			idle(1);
			n++;
		end
		if (rst_n !== 1'b1) begin
			errors++;
			$display("timeout waiting for reset release");
		end
		idle(2);
		// reset values
		err0 = errors;
		check_bit("direction", direction, 1'b0);
		check_para("token_bucket_para", token_bucket_para, `LCM_TB_RST);
		check_mac("direct_mac_addr", direct_mac_addr, 48'd0);
		check_period("time_slot_period", dut.time_slot_period, `LCM_SLOT_RST);
		check_bit("time_slot_flag", time_slot_flag, 1'b0);
		check_bit("pktin_ready", pktin_ready, 1'b1);
		$display("test reset: %s", (errors == err0) ? "ok" : "mismatch");
		for (int t = 0; t < NTEST; t++) begin
			run_test(t);
		end
		idle(4);
		$display("%0d tests, %0d checks, %0d errors", NTEST + 1, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// overall limit on the run
	initial begin
		#500000;
		$display("timeout, the run did not finish in time");
		$display("sim failed");
		$finish;
	end

endmodule

// ==== tb/tb_clk_gen.sv ====
// free running 10 ns clock, reset released 1 ns after the fifth rising edge to avoid an edge race
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset low for five cycles
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule
